// ==== iob_soc_bus.f ====
src/iob_bus_pkg.sv
src/iob_soc_map_pkg.sv
src/iob_addr_decode.sv
src/iob_split.sv
src/iob_sram.sv
src/iob_periph_regs.sv
src/iob_soc_bus.sv
dv/iob_soc_bus_asserts.sv
dv/iob_soc_bus_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the bus subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timescale 1ns/1ps \
   --top-module iob_soc_bus_tb -Mdir "$OBJ" -f iob_soc_bus.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

# Keep running past the first assertion so the testbench reports the result
"./$OBJ/Viob_soc_bus_tb" +verilator+error+limit+10 > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
   echo "Simulation reported a failure, see $LOG"
   exit 1
fi

if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

exit 0

// ==== dv/iob_soc_bus_tb.sv ====
module iob_soc_bus_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MEM_ADDR_W  = 12;
   localparam int BOOT_ADDR_W = 10;
   localparam int N_RAND      = 16;
   localparam int N_BOOT      = 8;

   localparam int IDX_LSB = iob_soc_map_pkg::PERIPH_BIT - iob_soc_map_pkg::N_PERIPH_W;

   localparam iob_bus_pkg::addr_t PER_BASE = 32'h8000_0000;
   localparam iob_bus_pkg::addr_t SCR_BASE =
      PER_BASE | (iob_bus_pkg::addr_t'(iob_soc_map_pkg::PERIPH_SCRATCH) << IDX_LSB);
   localparam iob_bus_pkg::addr_t MEM_MASK = (32'd1 << MEM_ADDR_W) - 32'd1;

   // One cycle per request, plus reset and idle gaps of each test
   localparam int STIM_CYCLES = 16 + 4 + (3 * N_RAND + 2) + (3 * N_BOOT + 4) + 16 + 14 + 4;
   localparam int MAX_CYCLES  = 2 * STIM_CYCLES;

   logic                   clk;
   logic                   rst;
   iob_bus_pkg::bus_req_t  req;
   iob_bus_pkg::bus_resp_t resp;

   int seed = 16652;
   int cycle_cnt = 0;

   iob_bus_pkg::addr_t wr_addr [N_RAND];

   iob_soc_bus #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .BOOT_ADDR_W(BOOT_ADDR_W)
   ) dut0 (
      .clk_i (clk),
      .rst_i (rst),
      .req_i (req),
      .resp_o(resp)
   );

   bind iob_soc_bus iob_soc_bus_asserts #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .BOOT_ADDR_W(BOOT_ADDR_W)
   ) chk0 (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .req_i (req_i),
      .resp_i(resp_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= MAX_CYCLES) begin
         $display("Run timed out after %0d cycles", cycle_cnt);
         $display("test failed");
         $fatal(1, "No progress before the cycle limit");
      end
   end

   always @(posedge clk) begin
      if (dut0.chk0.any_fail) begin
         $display("test failed");
         $fatal(1, "Bus checker flagged a wrong response");
      end
   end

   // Drive one request and wait for it to be accepted
   task automatic send(input iob_bus_pkg::addr_t a, input iob_bus_pkg::data_t wd,
                       input iob_bus_pkg::strb_t ws);
      req <= '{avalid: 1'b1, addr: a, wdata: wd, wstrb: ws};
      @(posedge clk);
      while (!resp.ready) begin
         @(posedge clk);
      end
   endtask

   task automatic idle(input int n);
      req <= '0;
      repeat (n) @(posedge clk);
   endtask

   function automatic iob_bus_pkg::addr_t rand_mem_addr();
      return iob_bus_pkg::addr_t'($random(seed)) & (MEM_MASK & ~32'd3);
   endfunction

   function automatic iob_bus_pkg::data_t rand_data();
      return iob_bus_pkg::data_t'($random(seed));
   endfunction

   task automatic sram_random();
      // Full words first so no byte stays unknown
      for (int i = 0; i < N_RAND; i++) begin
         wr_addr[i] = rand_mem_addr();
         send(wr_addr[i], rand_data(), 4'hF);
      end
      for (int i = 0; i < N_RAND; i++) begin
         send(wr_addr[i], rand_data(), iob_bus_pkg::strb_t'($random(seed)));
      end
      // Back-to-back reads
      for (int i = 0; i < N_RAND; i++) begin
         send(wr_addr[i], '0, '0);
      end
      idle(2);
   endtask

   task automatic boot_remap();
      iob_bus_pkg::addr_t a [N_BOOT];
      // Top of the SRAM, so the offset wraps around
      for (int i = 0; i < N_BOOT; i++) begin
         a[i] = 32'h0000_0C00 | (rand_mem_addr() & 32'h0000_03FC);
      end
      send(PER_BASE, 32'(iob_soc_map_pkg::BOOT_CTR_LOAD), 4'hF);
      for (int i = 0; i < N_BOOT; i++) begin
         send(a[i], rand_data(), 4'hF);
      end
      for (int i = 0; i < N_BOOT; i++) begin
         send(a[i], '0, '0);
      end
      send(PER_BASE, 32'(iob_soc_map_pkg::BOOT_CTR_RUN), 4'hF);
      for (int i = 0; i < N_BOOT; i++) begin
         send((a[i] + (32'd1 << BOOT_ADDR_W)) & MEM_MASK, '0, '0);
      end
      idle(2);
   endtask

   task automatic periph_regs();
      // Code 01 keeps run mode, upper bits go nowhere
      send(PER_BASE, {30'($random(seed)), 2'b01}, 4'hF);
      send(PER_BASE, '0, '0);
      send(PER_BASE, '0, 4'hF);
      send(PER_BASE, '0, '0);
      for (int i = 0; i < 4; i++) begin
         send(SCR_BASE | (iob_bus_pkg::addr_t'(i) << 2), rand_data(), 4'hF);
      end
      for (int i = 0; i < 4; i++) begin
         send(SCR_BASE | (iob_bus_pkg::addr_t'(i) << 2), rand_data(),
              iob_bus_pkg::strb_t'($random(seed)));
      end
      for (int i = 0; i < 4; i++) begin
         send(SCR_BASE | (iob_bus_pkg::addr_t'(i) << 2), '0, '0);
      end
   endtask

   task automatic unmapped_slots();
      iob_bus_pkg::addr_t slot;
      for (int s = 2; s < iob_soc_map_pkg::N_PERIPH; s++) begin
         slot = PER_BASE | (iob_bus_pkg::addr_t'(s) << IDX_LSB);
         send(slot, rand_data(), 4'hF);
         send(slot, '0, '0);
      end
      // Alternate followers on consecutive reads
      for (int i = 0; i < 4; i++) begin
         send(wr_addr[i], '0, '0);
         send(SCR_BASE | (iob_bus_pkg::addr_t'(i) << 2), '0, '0);
      end
      idle(2);
   endtask

   initial begin
      rst <= 1'b1;
      req <= '0;
      repeat (16) @(posedge clk);
      rst <= 1'b0;
      idle(4);
      sram_random();
      boot_remap();
      periph_regs();
      unmapped_slots();
      idle(4);
      if (dut0.chk0.any_fail == 1'b0) begin
         $display("test passed");
         $finish;
      end else begin
         $display("test failed");
         $fatal(1, "Bus checker flagged a wrong response");
      end
   end

endmodule

// ==== dv/iob_soc_bus_asserts.sv ====
module iob_soc_bus_asserts #(
   parameter int MEM_ADDR_W  = 12,
   parameter int BOOT_ADDR_W = 10
) (
   input  logic                    clk_i,
   input  logic                    rst_i,
   input  iob_bus_pkg::bus_req_t   req_i,
   input  iob_bus_pkg::bus_resp_t  resp_i
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int WORDS   = 2 ** (MEM_ADDR_W - 2);
   localparam int IDX_LSB = iob_soc_map_pkg::PERIPH_BIT - iob_soc_map_pkg::N_PERIPH_W;

   // Shadow state
   iob_bus_pkg::data_t            mem_q [WORDS];
   iob_bus_pkg::data_t            scratch_q [4];
   iob_soc_map_pkg::boot_ctr_t    boot_q;
   iob_bus_pkg::data_t            exp_q;
   logic                          seen_req_q;

   logic                          acc;
   logic                          rd_acc;
   logic                          wr_acc;
   logic                          is_per;
   iob_soc_map_pkg::periph_idx_t  idx;
   logic [1:0]                    scr;
   logic [MEM_ADDR_W-3:0]         word;
   iob_bus_pkg::data_t            exp_rd;

   bit fail_idle   = 1'b0;
   bit fail_rvalid = 1'b0;
   bit fail_quiet  = 1'b0;
   bit fail_data   = 1'b0;
   logic any_fail;

   // Word index after the boot remap, wrapped to the SRAM size
   function automatic logic [MEM_ADDR_W-3:0] mem_word(input iob_bus_pkg::addr_t a,
                                                      input iob_soc_map_pkg::boot_ctr_t b);
      iob_bus_pkg::addr_t phys;
      phys = a;
      if (b == iob_soc_map_pkg::BOOT_CTR_LOAD) begin
         phys = a + (iob_bus_pkg::addr_t'(1) << BOOT_ADDR_W);
      end
      return phys[MEM_ADDR_W-1:2];
   endfunction

   function automatic iob_bus_pkg::data_t merge(input iob_bus_pkg::data_t old,
                                                input iob_bus_pkg::data_t wd,
                                                input iob_bus_pkg::strb_t ws);
      iob_bus_pkg::data_t r;
      r = old;
      for (int b = 0; b < iob_bus_pkg::DATA_W / 8; b++) begin
         if (ws[b]) begin
            r[b*8 +: 8] = wd[b*8 +: 8];
         end
      end
      return r;
   endfunction

   assign acc    = req_i.avalid & resp_i.ready;
   assign rd_acc = acc & (req_i.wstrb == '0);
   assign wr_acc = acc & (req_i.wstrb != '0);
   assign is_per = req_i.addr[iob_soc_map_pkg::PERIPH_BIT];
   assign idx    = req_i.addr[IDX_LSB +: iob_soc_map_pkg::N_PERIPH_W];
   assign scr    = req_i.addr[3:2];
   assign word   = mem_word(req_i.addr, boot_q);

   always_comb begin
      exp_rd = '0;
      if (!is_per) begin
         exp_rd = mem_q[word];
      end else if (idx == iob_soc_map_pkg::PERIPH_BOOT) begin
         exp_rd = iob_bus_pkg::data_t'(boot_q);
      end else if (idx == iob_soc_map_pkg::PERIPH_SCRATCH) begin
         exp_rd = scratch_q[scr];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         boot_q     <= iob_soc_map_pkg::BOOT_CTR_RUN;
         seen_req_q <= 1'b0;
         for (int i = 0; i < 4; i++) begin
            scratch_q[i] <= '0;
         end
      end else begin
         if (req_i.avalid) begin
            seen_req_q <= 1'b1;
         end
         if (rd_acc) begin
            exp_q <= exp_rd;
         end
         if (wr_acc) begin
            if (!is_per) begin
               mem_q[word] <= merge(mem_q[word], req_i.wdata, req_i.wstrb);
            end else if (idx == iob_soc_map_pkg::PERIPH_BOOT && req_i.wstrb[0]) begin
               boot_q <= req_i.wdata[1:0];
            end else if (idx == iob_soc_map_pkg::PERIPH_SCRATCH) begin
               scratch_q[scr] <= merge(scratch_q[scr], req_i.wdata, req_i.wstrb);
            end
         end
      end
   end

   a_reset_idle: assert property (@(posedge clk_i) disable iff (rst_i)
      !seen_req_q |-> (!resp_i.rvalid && resp_i.ready))
   else begin
      fail_idle = 1'b1;
      $error("** Error reset_idle: expected rvalid 0 ready 1, actual rvalid %b ready %b",
             $sampled(resp_i.rvalid), $sampled(resp_i.ready));
   end

   a_read_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_acc |=> resp_i.rvalid)
   else begin
      fail_rvalid = 1'b1;
      $error("** Error read_rvalid: expected 1, actual %b", $sampled(resp_i.rvalid));
   end

   // Writes and idle cycles give no response
   a_no_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
      !rd_acc |=> !resp_i.rvalid)
   else begin
      fail_quiet = 1'b1;
      $error("** Error no_rvalid: expected 0, actual %b", $sampled(resp_i.rvalid));
   end

   a_read_data: assert property (@(posedge clk_i) disable iff (rst_i)
      rd_acc |=> (resp_i.rdata == exp_q))
   else begin
      fail_data = 1'b1;
      $error("** Error read_data: expected %h, actual %h",
             $sampled(exp_q), $sampled(resp_i.rdata));
   end

   assign any_fail = fail_idle | fail_rvalid | fail_quiet | fail_data;

endmodule

// ==== src/iob_soc_bus.sv ====
module iob_soc_bus #(
   parameter int MEM_ADDR_W  = 12,
   parameter int BOOT_ADDR_W = 10
) (
   input  logic                    clk_i,
   input  logic                    rst_i,

   // Master port
   input  iob_bus_pkg::bus_req_t   req_i,
   output iob_bus_pkg::bus_resp_t  resp_o
);

   // Decoded request
   iob_bus_pkg::bus_req_t         dec_req;
   logic                          periph_sel;
   iob_soc_map_pkg::periph_idx_t  periph_idx;

   // Follower links
   iob_bus_pkg::bus_req_t         mem_req;
   iob_bus_pkg::bus_resp_t        mem_resp;
   iob_bus_pkg::bus_req_t         per_req;
   iob_bus_pkg::bus_resp_t        per_resp;
   iob_soc_map_pkg::periph_idx_t  per_idx;

   // Memory mode from the boot-control register
   iob_soc_map_pkg::boot_ctr_t    boot_ctr;

   iob_addr_decode #(
      .MEM_ADDR_W (MEM_ADDR_W),
      .BOOT_ADDR_W(BOOT_ADDR_W)
   ) decode0 (
      .req_i       (req_i),
      .boot_ctr_i  (boot_ctr),
      .req_o       (dec_req),
      .periph_sel_o(periph_sel),
      .periph_idx_o(periph_idx)
   );

   iob_split split0 (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .req_i       (dec_req),
      .periph_sel_i(periph_sel),
      .periph_idx_i(periph_idx),
      .resp_o      (resp_o),
      .mem_req_o   (mem_req),
      .mem_resp_i  (mem_resp),
      .per_req_o   (per_req),
      .per_resp_i  (per_resp),
      .per_idx_o   (per_idx)
   );

   iob_sram #(
      .MEM_ADDR_W(MEM_ADDR_W)
   ) sram0 (
      .clk_i (clk_i),
      .req_i (mem_req),
      .resp_o(mem_resp)
   );

   iob_periph_regs periph0 (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .req_i     (per_req),
      .idx_i     (per_idx),
      .resp_o    (per_resp),
      .boot_ctr_o(boot_ctr)
   );

endmodule

// ==== src/iob_periph_regs.sv ====
module iob_periph_regs (
   input  logic                          clk_i,
   input  logic                          rst_i,

   input  iob_bus_pkg::bus_req_t         req_i,
   input  iob_soc_map_pkg::periph_idx_t  idx_i,
   output iob_bus_pkg::bus_resp_t        resp_o,

   output iob_soc_map_pkg::boot_ctr_t    boot_ctr_o
);

   localparam int N_SCRATCH = 4;
   localparam int SCR_IDX_W = $clog2(N_SCRATCH);
   localparam int N_BYTES   = iob_bus_pkg::DATA_W / 8;

   logic [iob_soc_map_pkg::N_PERIPH-1:0] slot_hit;
   logic [SCR_IDX_W-1:0]                 scr_sel;
   logic                                 wr_en;
   logic                                 rd_en;

   iob_soc_map_pkg::boot_ctr_t           boot_ctr_r;
   iob_bus_pkg::data_t                   scratch_r [N_SCRATCH];

   iob_bus_pkg::data_t                   rd_mux;
   iob_bus_pkg::data_t                   rdata_r;
   logic                                 rvalid_r;

   // One-hot slot decode
   assign slot_hit = {{(iob_soc_map_pkg::N_PERIPH-1){1'b0}}, 1'b1} << idx_i;

   assign scr_sel = req_i.addr[2 +: SCR_IDX_W];
   assign wr_en   = req_i.avalid & (req_i.wstrb != '0);
   assign rd_en   = req_i.avalid & (req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         boot_ctr_r <= iob_soc_map_pkg::BOOT_CTR_RUN;
         for (int i = 0; i < N_SCRATCH; i++) begin
            scratch_r[i] <= '0;
         end
      end else if (wr_en) begin
         // Only the two low bits of the boot word exist
         if (slot_hit[iob_soc_map_pkg::PERIPH_BOOT] && req_i.wstrb[0]) begin
            boot_ctr_r <= req_i.wdata[1:0];
         end
         if (slot_hit[iob_soc_map_pkg::PERIPH_SCRATCH]) begin
            for (int b = 0; b < N_BYTES; b++) begin
               if (req_i.wstrb[b]) begin
                  scratch_r[scr_sel][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
               end
            end
         end
      end
   end

   // Unmapped slots read zero
   always_comb begin
      rd_mux = '0;
      if (slot_hit[iob_soc_map_pkg::PERIPH_BOOT]) begin
         rd_mux = iob_bus_pkg::data_t'(boot_ctr_r);
      end else if (slot_hit[iob_soc_map_pkg::PERIPH_SCRATCH]) begin
         rd_mux = scratch_r[scr_sel];
      end
   end

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         rvalid_r <= 1'b0;
      end else begin
         rvalid_r <= rd_en;
      end
   end

   always_ff @(posedge clk_i) begin
      if (rd_en) begin
         rdata_r <= rd_mux;
      end
   end

   assign resp_o.ready  = 1'b1;
   assign resp_o.rvalid = rvalid_r;
   assign resp_o.rdata  = rdata_r;

   assign boot_ctr_o = boot_ctr_r;

endmodule

// ==== src/iob_sram.sv ====
module iob_sram #(
   parameter int MEM_ADDR_W = 12
) (
   input  logic                    clk_i,

   input  iob_bus_pkg::bus_req_t   req_i,
   output iob_bus_pkg::bus_resp_t  resp_o
);

   localparam int WORDS   = 2 ** (MEM_ADDR_W - 2);
   localparam int N_BYTES = iob_bus_pkg::DATA_W / 8;

   iob_bus_pkg::data_t mem [WORDS];

   logic [MEM_ADDR_W-3:0] word_addr;
   logic                  wr_en;
   logic                  rd_en;

   iob_bus_pkg::data_t    rdata_r;
   logic                  rvalid_r;

   // Word index, byte offset dropped
   assign word_addr = req_i.addr[MEM_ADDR_W-1:2];

   assign wr_en = req_i.avalid & (req_i.wstrb != '0);
   assign rd_en = req_i.avalid & (req_i.wstrb == '0);

   // Byte lanes written under strobe
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         for (int b = 0; b < N_BYTES; b++) begin
            if (req_i.wstrb[b]) begin
               mem[word_addr][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
            end
         end
      end
   end

   // One-cycle registered read
   always_ff @(posedge clk_i) begin
      rvalid_r <= rd_en;
      if (rd_en) begin
         rdata_r <= mem[word_addr];
      end
   end

   // Never stalls
   assign resp_o.ready  = 1'b1;
   assign resp_o.rvalid = rvalid_r;
   assign resp_o.rdata  = rdata_r;

endmodule

// ==== src/iob_split.sv ====
module iob_split (
   input  logic                          clk_i,
   input  logic                          rst_i,

   // Decoded master request
   input  iob_bus_pkg::bus_req_t         req_i,
   input  logic                          periph_sel_i,
   input  iob_soc_map_pkg::periph_idx_t  periph_idx_i,
   output iob_bus_pkg::bus_resp_t        resp_o,

   // SRAM follower
   output iob_bus_pkg::bus_req_t         mem_req_o,
   input  iob_bus_pkg::bus_resp_t        mem_resp_i,

   // Peripheral follower
   output iob_bus_pkg::bus_req_t         per_req_o,
   input  iob_bus_pkg::bus_resp_t        per_resp_i,
   output iob_soc_map_pkg::periph_idx_t  per_idx_o
);

   logic sel_ready;
   logic accept;
   logic rd_accept;

   // Follower of the read accepted last cycle
   logic sel_r;
   logic pend_r;

   // Same payload to both, avalid only toward the selected one
   always_comb begin
      mem_req_o        = req_i;
      mem_req_o.avalid = req_i.avalid & ~periph_sel_i;
      per_req_o        = req_i;
      per_req_o.avalid = req_i.avalid & periph_sel_i;
   end

   assign per_idx_o = periph_idx_i;

   // Ready follows the follower that the current request targets
   assign sel_ready = periph_sel_i ? per_resp_i.ready : mem_resp_i.ready;

   assign accept    = req_i.avalid & sel_ready;
   assign rd_accept = accept & (req_i.wstrb == '0);

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pend_r <= 1'b0;
         sel_r  <= 1'b0;
      end else begin
         pend_r <= rd_accept;
         if (rd_accept) begin
            sel_r <= periph_sel_i;
         end
      end
   end

   // Response steered by the registered selection, not the current request
   always_comb begin
      resp_o.ready = sel_ready;
      if (sel_r) begin
         resp_o.rdata  = per_resp_i.rdata;
         resp_o.rvalid = pend_r & per_resp_i.rvalid;
      end else begin
         resp_o.rdata  = mem_resp_i.rdata;
         resp_o.rvalid = pend_r & mem_resp_i.rvalid;
      end
   end

endmodule

// ==== src/iob_addr_decode.sv ====
module iob_addr_decode #(
   parameter int MEM_ADDR_W  = 12,
   parameter int BOOT_ADDR_W = 10
) (
   input  iob_bus_pkg::bus_req_t         req_i,
   input  iob_soc_map_pkg::boot_ctr_t    boot_ctr_i,

   output iob_bus_pkg::bus_req_t         req_o,
   output logic                          periph_sel_o,
   output iob_soc_map_pkg::periph_idx_t  periph_idx_o
);

   // Lowest bit of the peripheral index field
   localparam int IDX_LSB = iob_soc_map_pkg::PERIPH_BIT - iob_soc_map_pkg::N_PERIPH_W;

   // Offset added to memory addresses in load mode
   localparam iob_bus_pkg::addr_t BOOT_OFFSET = iob_bus_pkg::addr_t'(1) << BOOT_ADDR_W;

   // Memory addresses wrap inside the SRAM
   localparam iob_bus_pkg::addr_t MEM_MASK =
      (iob_bus_pkg::addr_t'(1) << MEM_ADDR_W) - iob_bus_pkg::addr_t'(1);

   // Peripheral addresses keep the offset below the index field
   localparam iob_bus_pkg::addr_t PER_MASK =
      (iob_bus_pkg::addr_t'(1) << IDX_LSB) - iob_bus_pkg::addr_t'(1);

   iob_bus_pkg::addr_t mem_addr;
   iob_bus_pkg::addr_t per_addr;
   logic               load_mode;

   assign periph_sel_o = req_i.addr[iob_soc_map_pkg::PERIPH_BIT];
   assign periph_idx_o = req_i.addr[IDX_LSB +: iob_soc_map_pkg::N_PERIPH_W];

   assign load_mode = (boot_ctr_i == iob_soc_map_pkg::BOOT_CTR_LOAD);

   // Remap then wrap, so the offset can roll over the top of the SRAM
   assign mem_addr = load_mode ? ((req_i.addr + BOOT_OFFSET) & MEM_MASK)
                               : (req_i.addr & MEM_MASK);

   assign per_addr = req_i.addr & PER_MASK;

   always_comb begin
      req_o = req_i;
      if (periph_sel_o) begin
         req_o.addr = per_addr;
      end else begin
         req_o.addr = mem_addr;
      end
   end

endmodule

// ==== src/iob_soc_map_pkg.sv ====
package iob_soc_map_pkg;

   // Top address bit selects the peripheral space
   localparam int PERIPH_BIT = iob_bus_pkg::ADDR_W - 1;

   // Peripheral index sits just below PERIPH_BIT
   localparam int N_PERIPH_W = 2;
   localparam int N_PERIPH   = 2 ** N_PERIPH_W;

   typedef logic [N_PERIPH_W-1:0] periph_idx_t;

   // Mapped slots, the others read as zero
   localparam periph_idx_t PERIPH_BOOT    = 2'd0;
   localparam periph_idx_t PERIPH_SCRATCH = 2'd1;

   // Boot-control register codes
   typedef logic [1:0] boot_ctr_t;

   localparam boot_ctr_t BOOT_CTR_RUN  = 2'b00;
   // Memory seen past the boot region
   localparam boot_ctr_t BOOT_CTR_LOAD = 2'b10;

endpackage

// ==== src/iob_bus_pkg.sv ====
package iob_bus_pkg;

   // Native bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // Byte address, data word and write strobes
   typedef logic [ADDR_W-1:0]   addr_t;
   typedef logic [DATA_W-1:0]   data_t;
   typedef logic [DATA_W/8-1:0] strb_t;

   // Request from the master or the splitter
   // A zero wstrb marks a read
   typedef struct packed {
      logic  avalid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } bus_req_t;

   // Response from a follower or the splitter
   // rvalid pulses once per accepted read
   typedef struct packed {
      data_t rdata;
      logic  rvalid;
      logic  ready;
   } bus_resp_t;

endpackage
